// ==== src.f ====
+incdir+hw
hw/etx_pkg.sv
hw/etx_edge_align.sv
hw/etx_protocol.sv
hw/etx_io.sv
hw/etx_top.sv
testbench/etx_tb.sv

// ==== Makefile ====
# Verilator build and run for the etx transmit link

VERILATOR  ?= verilator
TOP        ?= etx_tb
BUILD_DIR  ?= build
# empty keeps the watchdog time computed in the testbench
TIMEOUT_NS ?=

VFLAGS = --binary --timing --timescale 1ns/10ps -Wno-fatal \
         --top-module $(TOP) -Mdir $(BUILD_DIR) \
         $(if $(TIMEOUT_NS),-GTIMEOUT_NS=$(TIMEOUT_NS))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP BUILD_DIR TIMEOUT_NS"

test:
	$(VERILATOR) $(VFLAGS) -f src.f
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== testbench/etx_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "etx_consts.svh"

module etx_tb
   import etx_pkg::*;
();

   localparam int SLOW_NS     = 10;
   localparam int N_RANDOM    = 20;                  // back-to-back packets
   localparam int WAIT_LIMIT  = 16;                  // slow cycles per poll loop
   localparam int TEST_CYCLES = 50 + N_RANDOM * 2;   // rough length of all tests
   parameter  int TIMEOUT_NS  = 4 * TEST_CYCLES * SLOW_NS;

   logic                  tx_lclk_io;
   logic                  tx_lclk90;
   logic                  tx_lclk_div4;
   logic                  rst_n;
   logic                  access;
   etx_packet_t           packet;
   logic                  tx_wait;
   logic                  txi_wr_wait_p;
   logic                  txi_wr_wait_n;
   logic                  txi_rd_wait_p;
   logic                  txi_rd_wait_n;
   logic                  txo_lclk_p;
   logic                  txo_lclk_n;
   logic                  txo_frame_p;
   logic                  txo_frame_n;
   logic [`ETX_PIN_W-1:0] txo_data_p;
   logic [`ETX_PIN_W-1:0] txo_data_n;

   logic [15:0]           lfsr = 16'd25987;          // galois state
   etx_packet_t           exp_q [$];                 // accepted, not yet seen on pins
   int                    tx_count = 0;
   int                    rx_count = 0;
   logic [7:0]            rise_byte;
   logic                  rise_frame = 1'b0;
   logic [15:0]           prev_lane = '0;            // may be lane 0 of a head beat
   logic                  prev_frame = 1'b0;
   logic [15:0]           lanes [8];
   int                    lane_idx = 0;              // 0 while idle

   etx_top #(.ETYPE(0)) i_dut
   (
      .tx_lclk_io    (tx_lclk_io),
      .tx_lclk90     (tx_lclk90),
      .tx_lclk_div4  (tx_lclk_div4),
      .rst_n         (rst_n),
      .access        (access),
      .packet        (packet),
      .tx_wait       (tx_wait),
      .txi_wr_wait_p (txi_wr_wait_p),
      .txi_wr_wait_n (txi_wr_wait_n),
      .txi_rd_wait_p (txi_rd_wait_p),
      .txi_rd_wait_n (txi_rd_wait_n),
      .txo_lclk_p    (txo_lclk_p),
      .txo_lclk_n    (txo_lclk_n),
      .txo_frame_p   (txo_frame_p),
      .txo_frame_n   (txo_frame_n),
      .txo_data_p    (txo_data_p),
      .txo_data_n    (txo_data_n)
   );

   //########################################################################
   // clocks, fast rises on every slow rise
   //########################################################################
   initial
   begin
      tx_lclk_div4 = 1'b0;
      forever #(SLOW_NS / 2) tx_lclk_div4 = ~tx_lclk_div4;
   end

   initial
   begin
      tx_lclk_io = 1'b1;
      forever #1.25 tx_lclk_io = ~tx_lclk_io;
   end

   initial
   begin
      tx_lclk90 = 1'b0;
      #0.62;                                         // quarter of the fast period
      forever
      begin
         tx_lclk90 = ~tx_lclk90;
         #1.25;
      end
   end

   //########################################################################
   // helpers
   //########################################################################
   task automatic stop_failed(input string why);
      $display("Done: errors found");
      $fatal(1, "%s", why);
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
         stop_failed("value mismatch");
      end
   endtask

   task automatic step;
      @(posedge tx_lclk_div4);
      #1;                                            // drive point
   endtask

   // one lfsr step per bit, lsb out first
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         r    = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic etx_packet_t random_packet();
      etx_packet_t p;
      p.write    = 1'(rand_bits(1));
      p.datamode = 2'(rand_bits(2));
      p.ctrlmode = 5'(rand_bits(5));
      p.dstaddr  = rand_bits(32);
      p.data     = rand_bits(32);
      p.srcaddr  = rand_bits(32);
      return p;
   endfunction

   //########################################################################
   // pin monitor
   //########################################################################
   task automatic check_pins;
      check_value("txo_data_n", txo_data_n, {~txo_data_p});   // braces keep 8 bits
      check_value("txo_frame_n", txo_frame_n, {~txo_frame_p});
      check_value("txo_lclk_n", txo_lclk_n, {~txo_lclk_p});
   endtask

   // rebuild fields by the beat layout, lanes low first
   task automatic check_packet;
      etx_packet_t exp;
      logic [63:0] beat0;
      logic [63:0] beat1;
      beat0 = {lanes[3], lanes[2], lanes[1], lanes[0]};
      beat1 = {lanes[7], lanes[6], lanes[5], lanes[4]};
      if (exp_q.size() == 0)
         stop_failed("a frame appeared on the pins with no packet accepted");
      exp = exp_q.pop_front();
      check_value("head padding", beat0[63:40], 0);
      check_value("write", beat0[39], exp.write);            // command byte msb
      check_value("datamode", beat0[38:37], exp.datamode);
      check_value("ctrlmode", beat0[36:32], exp.ctrlmode);
      check_value("dstaddr", beat0[31:0], exp.dstaddr);
      check_value("data", beat1[63:32], exp.data);
      check_value("srcaddr", beat1[31:0], exp.srcaddr);
      rx_count++;
   endtask

   always @(posedge txo_lclk_p)
   begin
      #0.1;                                          // past the edge, data mid eye
      check_pins();
      rise_byte  = txo_data_p;                       // high byte of the lane
      rise_frame = txo_frame_p;
   end

   always @(negedge txo_lclk_p)
   begin : lane_collect
      logic [15:0] cur_lane;
      logic        cur_frame;
      #0.1;
      check_pins();
      cur_lane  = {rise_byte, txo_data_p};
      cur_frame = txo_frame_p;
      if (cur_frame !== rise_frame)
         stop_failed("frame pin changed between the two halves of a lane");
      if (lane_idx == 0)
      begin
         // frame rises on lane 1, lane 0 is the one just before
         if (cur_frame && !prev_frame)
         begin
            lanes[0] = prev_lane;
            lanes[1] = cur_lane;
            lane_idx = 2;
         end
      end
      else
      begin
         if (!cur_frame)
            stop_failed("frame dropped in the middle of a packet");
         lanes[lane_idx] = cur_lane;
         lane_idx++;
         if (lane_idx == 8)
         begin
            check_packet();
            lane_idx = 0;
         end
      end
      prev_lane  = cur_lane;
      prev_frame = cur_frame;
   end

   //########################################################################
   // fabric side
   //########################################################################
   task automatic send_packet(input etx_packet_t p);
      int guard;
      guard  = 0;
      access = 1'b1;
      packet = p;
      while (tx_wait)                                // held until wait low
      begin
         step();
         guard++;
         if (guard > WAIT_LIMIT)
            stop_failed("wait stayed high, packet never accepted");
      end
      exp_q.push_back(p);                            // taken on the coming edge
      tx_count++;
      step();
      access = 1'b0;
      check_value("tx_wait", tx_wait, 1);            // second beat pending
   endtask

   task automatic wait_drained;
      int guard;
      guard = 0;
      while (rx_count != tx_count)
      begin
         step();
         guard++;
         if (guard > WAIT_LIMIT)
            stop_failed("accepted packets did not appear on the pins");
      end
   endtask

   //########################################################################
   // directed tests
   //########################################################################
   task automatic test_idle;
      check_value("tx_wait", tx_wait, 0);
      repeat (16)
      begin
         #0.6;
         check_value("txo_frame_p", txo_frame_p, 0);
         check_value("txo_frame_n", txo_frame_n, 1);
         check_value("txo_data_p", txo_data_p, 0);   // idle beats are zero
      end
      step();
   endtask

   task automatic test_single_write;
      etx_packet_t p;
      p.write    = 1'b1;
      p.datamode = 2'b10;
      p.ctrlmode = 5'h05;
      p.dstaddr  = 32'h8000_1234;
      p.data     = 32'hdead_beef;
      p.srcaddr  = 32'h0000_0810;
      send_packet(p);
      wait_drained();
   endtask

   task automatic test_back_to_back;
      repeat (N_RANDOM)
         send_packet(random_packet());
      wait_drained();
   endtask

   task automatic test_write_wait;
      etx_packet_t p;
      int          guard;
      p             = random_packet();
      guard         = 0;
      txi_wr_wait_p = 1'b1;                          // differential, n opposite
      txi_wr_wait_n = 1'b0;
      while (!tx_wait)
      begin
         step();
         guard++;
         if (guard > WAIT_LIMIT)
            stop_failed("held write wait never raised wait");
      end
      access = 1'b1;
      packet = p;
      repeat (6)
      begin
         step();
         check_value("tx_wait", tx_wait, 1);
         check_value("txo_frame_p", txo_frame_p, 0);  // nothing leaves while held
      end
      txi_wr_wait_p = 1'b0;
      txi_wr_wait_n = 1'b1;
      send_packet(p);                                // goes once wait drops
      wait_drained();
   endtask

   task automatic test_read_pulse;
      int guard;
      guard         = 0;
      txi_rd_wait_p = 1'b1;
      #2.5;                                          // one fast cycle
      txi_rd_wait_p = 1'b0;
      step();
      while (!tx_wait)
      begin
         step();
         guard++;
         if (guard > 4)
            stop_failed("short read wait pulse was lost");
      end
      step();
      check_value("tx_wait", tx_wait, 1);            // second slow cycle
      guard = 0;
      while (tx_wait)
      begin
         step();
         guard++;
         if (guard > WAIT_LIMIT)
            stop_failed("wait stuck high after read wait pulse");
      end
   endtask

   //########################################################################
   // main sequence and watchdog
   //########################################################################
   initial
   begin
      rst_n         = 1'b0;
      access        = 1'b0;
      packet        = '0;
      txi_wr_wait_p = 1'b0;
      txi_wr_wait_n = 1'b1;
      txi_rd_wait_p = 1'b0;
      txi_rd_wait_n = 1'b1;
      repeat (8) @(posedge tx_lclk_div4);
      #1 rst_n = 1'b1;
      step();
      test_idle();
      test_single_write();
      test_back_to_back();
      test_write_wait();
      test_read_pulse();
      wait_drained();
      $display("Done: no errors");
      $finish;
   end

   initial
   begin
      #(TIMEOUT_NS);
      stop_failed("watchdog expired before the tests finished");
   end

endmodule

`default_nettype wire

// ==== hw/etx_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "etx_consts.svh"

module etx_top import etx_pkg::*;
#(
   parameter int ETYPE = 0                         // wait pin style, see etx_io
)
(
   input  logic                  tx_lclk_io,       // fast
   input  logic                  tx_lclk90,        // fast, shifted, for lclk out
   input  logic                  tx_lclk_div4,     // slow
   input  logic                  rst_n,
   // fabric
   input  logic                  access,
   input  etx_packet_t           packet,
   output logic                  tx_wait,
   // link pins
   input  logic                  txi_wr_wait_p,
   input  logic                  txi_wr_wait_n,
   input  logic                  txi_rd_wait_p,
   input  logic                  txi_rd_wait_n,
   output logic                  txo_lclk_p,
   output logic                  txo_lclk_n,
   output logic                  txo_frame_p,
   output logic                  txo_frame_n,
   output logic [`ETX_PIN_W-1:0] txo_data_p,
   output logic [`ETX_PIN_W-1:0] txo_data_n
);

   logic      firstedge;                           // fast domain load strobe
   etx_slow_t slow_beat;                           // protocol -> serializer
   etx_wait_t link_wait;                           // serializer -> protocol

   etx_edge_align i_edge_align
   (
      .tx_lclk_io   (tx_lclk_io),
      .tx_lclk_div4 (tx_lclk_div4),
      .rst_n        (rst_n),
      .firstedge    (firstedge)
   );

   etx_protocol i_protocol
   (
      .tx_lclk_div4 (tx_lclk_div4),
      .rst_n        (rst_n),
      .access       (access),
      .packet       (packet),
      .tx_wait      (tx_wait),
      .link_wait    (link_wait),
      .slow_beat    (slow_beat)
   );

   etx_io #(.ETYPE(ETYPE)) i_io
   (
      .tx_lclk_io    (tx_lclk_io),
      .tx_lclk90     (tx_lclk90),
      .tx_lclk_div4  (tx_lclk_div4),
      .rst_n         (rst_n),
      .firstedge     (firstedge),
      .slow_beat     (slow_beat),
      .txi_wr_wait_p (txi_wr_wait_p),
      .txi_wr_wait_n (txi_wr_wait_n),
      .txi_rd_wait_p (txi_rd_wait_p),
      .txi_rd_wait_n (txi_rd_wait_n),
      .txo_lclk_p    (txo_lclk_p),
      .txo_lclk_n    (txo_lclk_n),
      .txo_frame_p   (txo_frame_p),
      .txo_frame_n   (txo_frame_n),
      .txo_data_p    (txo_data_p),
      .txo_data_n    (txo_data_n),
      .link_wait     (link_wait)
   );

endmodule

`default_nettype wire

// ==== hw/etx_io.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "etx_consts.svh"

module etx_io import etx_pkg::*;
#(
   parameter int ETYPE = 0                         // 0 diff wait pins, 1 single ended
)
(
   input  logic                  tx_lclk_io,       // fast clock
   input  logic                  tx_lclk90,        // fast clock, 90 deg shifted
   input  logic                  tx_lclk_div4,     // slow clock
   input  logic                  rst_n,
   input  logic                  firstedge,        // load strobe from etx_edge_align
   input  etx_slow_t             slow_beat,
   // pins
   input  logic                  txi_wr_wait_p,
   input  logic                  txi_wr_wait_n,
   input  logic                  txi_rd_wait_p,
   input  logic                  txi_rd_wait_n,    // not connected, rd wait is single ended
   output logic                  txo_lclk_p,
   output logic                  txo_lclk_n,
   output logic                  txo_frame_p,
   output logic                  txo_frame_n,
   output logic [`ETX_PIN_W-1:0] txo_data_p,
   output logic [`ETX_PIN_W-1:0] txo_data_n,
   // slow domain
   output etx_wait_t             link_wait
);

   logic [`ETX_SLOW_DW-1:0] shift_data;            // lane 0 in the low bits
   logic [`ETX_FRAME_W-1:0] shift_frame;           // lane 0 in the msb
   logic [`ETX_LANE_W-1:0]  lane_data;
   logic                    lane_frame;
   logic [`ETX_PIN_W:0]     ddr_rise_q;            // {frame, high byte}
   logic [`ETX_PIN_W-1:0]   ddr_fall_q;            // low byte
   logic [`ETX_PIN_W:0]     ddr_out;
   logic                    lclk_rise_q;
   logic                    lclk_ddr;
   logic                    wr_async;
   logic                    rd_async;
   logic [`ETX_FRAME_W-1:0] wr_hist;               // last slow period of samples
   logic [`ETX_FRAME_W-1:0] rd_hist;
   etx_wait_t               wait_sync;
   etx_wait_t               wait_s1;
   etx_wait_t               wait_s2;

   //#######################################################################
   // lane serializer, fast domain
   //#######################################################################
   always_ff @(posedge tx_lclk_io or negedge rst_n)
   begin
      if (!rst_n)
      begin
         shift_data  <= '0;
         shift_frame <= '0;
      end
      else if (firstedge)
      begin
         shift_data  <= slow_beat.data;            // new beat every 4 fast cycles
         shift_frame <= slow_beat.frame;
      end
      else
      begin
         shift_data  <= {{`ETX_LANE_W{1'b0}}, shift_data[`ETX_SLOW_DW-1:`ETX_LANE_W]};
         shift_frame <= {shift_frame[`ETX_FRAME_W-2:0], 1'b0};
      end
   end

   assign lane_data  = shift_data[`ETX_LANE_W-1:0];
   assign lane_frame = shift_frame[`ETX_FRAME_W-1];

   //#######################################################################
   // ddr output cells, same edge capture
   //#######################################################################
   // both halves taken on the rising edge, fall half shown while clock low
   always_ff @(posedge tx_lclk_io or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ddr_rise_q <= '0;
         ddr_fall_q <= '0;
      end
      else
      begin
         ddr_rise_q <= {lane_frame, lane_data[`ETX_LANE_W-1:`ETX_PIN_W]};
         ddr_fall_q <= lane_data[`ETX_PIN_W-1:0];
      end
   end

   // frame held over both phases
   assign ddr_out = {ddr_rise_q[`ETX_PIN_W],
                     tx_lclk_io ? ddr_rise_q[`ETX_PIN_W-1:0] : ddr_fall_q};

   // forwarded clock, 1 then 0, centred on the data eye
   always_ff @(posedge tx_lclk90 or negedge rst_n)
   begin
      if (!rst_n)
         lclk_rise_q <= 1'b0;
      else
         lclk_rise_q <= 1'b1;
   end

   assign lclk_ddr = tx_lclk90 & lclk_rise_q;      // low phase always 0

   // differential drivers
   assign txo_data_p  = ddr_out[`ETX_PIN_W-1:0];
   assign txo_data_n  = ~ddr_out[`ETX_PIN_W-1:0];
   assign txo_frame_p = ddr_out[`ETX_PIN_W];
   assign txo_frame_n = ~ddr_out[`ETX_PIN_W];
   assign txo_lclk_p  = lclk_ddr;
   assign txo_lclk_n  = ~lclk_ddr;

   //#######################################################################
   // wait inputs
   //#######################################################################
   generate
      if (ETYPE == 1)
      begin : g_wr_single
         assign wr_async = txi_wr_wait_p;
      end
      else
      begin : g_wr_diff
         assign wr_async = txi_wr_wait_p & ~txi_wr_wait_n;   // receiver, p high n low
      end
   endgenerate

   assign rd_async = txi_rd_wait_p;                 // single ended on the board

   // falling edge sampler, keeps a hit for a full slow period
   always_ff @(negedge tx_lclk_io or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_hist <= '0;
         rd_hist <= '0;
      end
      else
      begin
         wr_hist <= {wr_hist[`ETX_FRAME_W-2:0], wr_async};
         rd_hist <= {rd_hist[`ETX_FRAME_W-2:0], rd_async};
      end
   end

   assign wait_sync = {|wr_hist, |rd_hist};         // wr first, as in etx_wait_t

   // two slow stages, or'd so a pulse lasts at least two slow cycles
   always_ff @(posedge tx_lclk_div4 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wait_s1 <= '0;
         wait_s2 <= '0;
      end
      else
      begin
         wait_s1 <= wait_sync;
         wait_s2 <= wait_s1;
      end
   end

   assign link_wait = wait_s1 | wait_s2;

endmodule

`default_nettype wire

// ==== hw/etx_protocol.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "etx_consts.svh"

module etx_protocol import etx_pkg::*;
(
   input  logic        tx_lclk_div4,   // slow clock
   input  logic        rst_n,
   // fabric
   input  logic        access,         // held until accepted
   input  etx_packet_t packet,
   output logic        tx_wait,        // pushback to fabric
   // link
   input  etx_wait_t   link_wait,      // stretched waits from etx_io
   output etx_slow_t   slow_beat       // one beat per slow cycle
);

   localparam int CMD_W  = 8;                         // write, datamode, ctrlmode
   localparam int ADDR_W = 32;
   localparam int PAD_W  = `ETX_SLOW_DW - CMD_W - ADDR_W;  // zero fill in the head beat

   //#######################################################################
   // declarations
   //#######################################################################
   logic                    accept;     // packet taken this cycle
   logic                    pending;    // body beat still to go
   logic [CMD_W-1:0]        cmd;        // command byte
   logic [`ETX_SLOW_DW-1:0] body_q;     // data over srcaddr, held one cycle
   etx_slow_t               beat_head;
   etx_slow_t               beat_body;

   //#######################################################################
   // acceptance
   //#######################################################################
   // pending covers the body beat, so a new packet never collides with it
   assign tx_wait = link_wait.wr | link_wait.rd | pending;
   assign accept  = access & ~tx_wait;

   //#######################################################################
   // beat layout
   //#######################################################################
   assign cmd = {packet.write, packet.datamode, packet.ctrlmode};  // msb first

   always_comb
   begin
      // head: padding, command byte, destination
      beat_head.data  = {{PAD_W{1'b0}}, cmd, packet.dstaddr};
      beat_head.frame = `ETX_FRAME_HEAD;     // lane 0 unframed
      // body: data word above the return address
      beat_body.data  = body_q;
      beat_body.frame = `ETX_FRAME_BODY;
   end

   // body payload captured with the head, sent one cycle later
   always_ff @(posedge tx_lclk_div4)
   begin
      if (accept)
         body_q <= {packet.data, packet.srcaddr};
   end

   //#######################################################################
   // beat sequencing
   //#######################################################################
   // idle -> head -> body -> idle
   // the body beat is never stalled, wait only blocks the next accept
   always_ff @(posedge tx_lclk_div4 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         pending   <= 1'b0;
         slow_beat <= '0;                     // zero frame on the pins
      end
      else if (accept)
      begin
         pending   <= 1'b1;
         slow_beat <= beat_head;              // head out one cycle after accept
      end
      else if (pending)
      begin
         pending   <= 1'b0;
         slow_beat <= beat_body;              // body right behind it
      end
      else
      begin
         slow_beat <= '0;                     // idle beat between packets
      end
   end

endmodule

`default_nettype wire

// ==== hw/etx_edge_align.sv ====
`timescale 1ns/10ps
`default_nettype none

module etx_edge_align
(
   input  logic tx_lclk_io,        // fast clock
   input  logic tx_lclk_div4,      // slow clock
   input  logic rst_n,
   output logic firstedge          // high up to the first fast edge after a slow edge
);

   logic toggle_slow;              // flips on every slow edge
   logic toggle_fast;              // fast copy, one fast edge behind

   always_ff @(posedge tx_lclk_div4 or negedge rst_n)
   begin
      if (!rst_n)
         toggle_slow <= 1'b0;
      else
         toggle_slow <= ~toggle_slow;
   end

   // catches up on the first fast edge after the flip
   always_ff @(posedge tx_lclk_io or negedge rst_n)
   begin
      if (!rst_n)
         toggle_fast <= 1'b0;
      else
         toggle_fast <= toggle_slow;
   end

   // mismatch lasts exactly one fast cycle, no phase assumption needed
   assign firstedge = toggle_slow ^ toggle_fast;

endmodule

`default_nettype wire

// ==== hw/etx_pkg.sv ====
`default_nettype none
`include "etx_consts.svh"

package etx_pkg;

   //#######################################################################
   // fabric side
   //#######################################################################
   typedef struct packed
   {
      logic        write;          // 1 = write transaction
      logic [1:0]  datamode;       // access size
      logic [4:0]  ctrlmode;
      logic [31:0] dstaddr;
      logic [31:0] data;
      logic [31:0] srcaddr;        // return address for reads
   } etx_packet_t;

   //#######################################################################
   // link side
   //#######################################################################
   // one slow-clock beat, serialized as four 16 bit lanes
   typedef struct packed
   {
      logic [`ETX_SLOW_DW-1:0] data;
      logic [`ETX_FRAME_W-1:0] frame;  // bit 3 goes with lane 0
   } etx_slow_t;

   // pushback from the far end
   typedef struct packed
   {
      logic wr;                    // write wait
      logic rd;                    // read wait
   } etx_wait_t;

endpackage

`default_nettype wire

// ==== hw/etx_consts.svh ====
`ifndef ETX_CONSTS_SVH
`define ETX_CONSTS_SVH

//##########################################################################
// packet and link geometry
//##########################################################################
`define ETX_PW          104        // fabric packet, same width as etx_packet_t
`define ETX_SLOW_DW     64         // payload of one slow beat
`define ETX_FRAME_W     4          // frame bits per beat, one per fast lane
`define ETX_PIN_W       8          // ddr data pins
`define ETX_LANE_W      (2*`ETX_PIN_W) // one lane, rise byte + fall byte

//##########################################################################
// frame patterns, msb goes with lane 0
//##########################################################################
// lane 0 of the head beat goes out unframed, so frame rises at lane 1
`define ETX_FRAME_HEAD  4'b0111
`define ETX_FRAME_BODY  4'b1111    // body beat framed on all lanes

`endif
